// ==== data_ram.sv ====
`timescale 1ns/1ps
`include "mem_params.svh"

module data_ram
    import lsu_pkg::*, exc_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst_n,
    // request strobe from req stage
    input  logic                   ram_valid,
    input  mem_op_e                ram_op,
    input  logic [`MEM_ADDR_W-1:0] ram_addr,      // word aligned
    input  logic [`MEM_BE_W-1:0]   ram_be,
    input  logic [`MEM_DATA_W-1:0] ram_wdata,
    // completion to resp stage
    output logic                   data_valid,
    output logic [`MEM_DATA_W-1:0] rdata,
    output logic [`MEM_EXP_W-1:0]  ram_exception,
    output logic [`MEM_ADDR_W-1:0] ram_badv
);

    localparam int IDX_W = $clog2(`MEM_RAM_WORDS);
    localparam int CNT_W = $clog2(`MEM_RAM_LAT + 1);

    logic [`MEM_DATA_W-1:0] mem_q [0:`MEM_RAM_WORDS-1];

    ram_state_e             state;
    logic [CNT_W-1:0]       lat_cnt;       // cycles since strobe
    logic                   take;
    logic                   in_range;
    logic [IDX_W-1:0]       word_idx;
    logic [`MEM_EXP_W-1:0]  range_exc;

    // one access at a time, stall upstream guarantees idle
    assign take     = ram_valid & (state == ram_idle);
    assign in_range = (ram_addr[`MEM_ADDR_W-1:2] < `MEM_RAM_WORDS);
    assign word_idx = ram_addr[IDX_W+1:2];

    always_comb begin
        range_exc           = '0;
        range_exc[exc_adem] = ~in_range;
    end

    // latency fsm
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state      <= ram_idle;
            lat_cnt    <= '0;
            data_valid <= 1'b0;
        end else begin
            data_valid <= 1'b0;                   // single cycle pulse
            case (state)
                ram_idle: begin
                    if (take) begin
                        lat_cnt <= CNT_W'(1);
                        if (`MEM_RAM_LAT == 1) begin
                            data_valid <= 1'b1;   // done right away
                        end else begin
                            state <= ram_busy;
                        end
                    end
                end
                ram_busy: begin
                    lat_cnt <= lat_cnt + 1'b1;
                    if (lat_cnt + 1'b1 == CNT_W'(`MEM_RAM_LAT)) begin
                        data_valid <= 1'b1;
                        state      <= ram_idle;
                    end
                end
                default: state <= ram_idle;
            endcase
        end
    end

    // byte enabled write, skipped when out of range
    always_ff @(posedge clk) begin
        if (take && in_range && ram_op == op_store) begin
            for (int i = 0; i < `MEM_BE_W; i++) begin
                if (ram_be[i]) begin
                    mem_q[word_idx][8*i +: 8] <= ram_wdata[8*i +: 8];
                end
            end
        end
    end

    // response payload, held until next strobe
    always_ff @(posedge clk) begin
        if (take) begin
            if (in_range && ram_op == op_load) begin
                rdata <= mem_q[word_idx];
            end else begin
                rdata <= '0;                      // stores and bad addr read zero
            end
            ram_exception <= range_exc;
            ram_badv      <= in_range ? '0 : ram_addr;
        end
    end

endmodule

// ==== exc_pkg.sv ====
package exc_pkg;

    // bit positions inside the exception flag vector
    typedef enum logic [2:0] {
        exc_ale  = 3'd0,   // misaligned address, raised in mem stage
        exc_adem = 3'd1,   // address out of range, raised by data ram
        exc_ipe  = 3'd2,   // upstream, passes through
        exc_ine  = 3'd3,   // upstream
        exc_sys  = 3'd4,   // upstream
        exc_brk  = 3'd5,   // upstream
        exc_int  = 3'd6    // upstream
    } exc_bit_e;

endpackage

// ==== list.f ====
+incdir+.
lsu_pkg.sv
exc_pkg.sv
mem_req_stage.sv
mem_resp_stage.sv
data_ram.sv
mem_stage_top.sv
mem_stage_tb.sv

// ==== lsu_pkg.sv ====
package lsu_pkg;

    // access size, same coding as the execute stage uses
    typedef enum logic [1:0] {
        width_byte = 2'd0,   // lb/sb
        width_half = 2'd1,   // lh/sh
        width_word = 2'd2    // lw/sw
    } access_width_e;

    // memory operation, store is 1 like the cache op bit
    typedef enum logic [0:0] {
        op_load  = 1'b0,
        op_store = 1'b1
    } mem_op_e;

    // data ram control fsm
    typedef enum logic [0:0] {
        ram_idle = 1'b0,     // ready for a strobe
        ram_busy = 1'b1      // counting down latency
    } ram_state_e;

endpackage

// ==== mem_params.svh ====
`ifndef MEM_PARAMS_SVH
`define MEM_PARAMS_SVH

// datapath widths
`define MEM_DATA_W     32   // data word
`define MEM_ADDR_W     32   // byte address
`define MEM_RD_W       5    // dest register index

// exception vector, bit positions live in exc_pkg
`define MEM_EXP_W      7

// data ram geometry
`define MEM_RAM_WORDS  256  // depth in words, byte addr >= 4*depth is out of range

// cycles from strobe to data_valid, 1 or more
`define MEM_RAM_LAT    2

// bytes per data word
`define MEM_BE_W       (`MEM_DATA_W / 8)

`endif

// ==== mem_req_stage.sv ====
`timescale 1ns/1ps
`include "mem_params.svh"

module mem_req_stage
    import lsu_pkg::*, exc_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst_n,
    // from execute
    input  logic                   mem_en_in,
    input  logic [`MEM_RD_W-1:0]   mem_rd_in,
    input  logic [`MEM_DATA_W-1:0] mem_data_in,
    input  logic [`MEM_ADDR_W-1:0] mem_base,
    input  logic [`MEM_ADDR_W-1:0] mem_offset,
    input  mem_op_e                mem_op_in,
    input  access_width_e          mem_width_in,
    input  logic                   mem_sign_in,
    input  logic [`MEM_EXP_W-1:0]  mem_exp_in,
    input  logic                   stall,          // global, from resp stage
    // to data ram
    output logic                   ram_valid,
    output mem_op_e                ram_op,
    output logic [`MEM_ADDR_W-1:0] ram_addr,
    output logic [`MEM_BE_W-1:0]   ram_be,
    output logic [`MEM_DATA_W-1:0] ram_wdata,
    // stage register to resp stage
    output logic                   s1_en,
    output logic [`MEM_RD_W-1:0]   s1_rd,
    output access_width_e          s1_width,
    output logic                   s1_sign,
    output logic [1:0]             s1_addr_lo,
    output logic [`MEM_EXP_W-1:0]  s1_exp,
    output logic [`MEM_ADDR_W-1:0] s1_badv
);

    logic [`MEM_ADDR_W-1:0] eff_addr;
    logic                   misalign;
    logic                   accept;
    logic [`MEM_BE_W-1:0]   base_be;
    logic [`MEM_EXP_W-1:0]  exp_next;

    assign eff_addr = mem_base + mem_offset;          // agu
    assign accept   = mem_en_in & ~stall;

    // alignment check and unshifted byte mask per width
    always_comb begin
        case (mem_width_in)
            width_byte: begin
                misalign = 1'b0;
                base_be  = 4'b0001;
            end
            width_half: begin
                misalign = eff_addr[0];               // odd half
                base_be  = 4'b0011;
            end
            default: begin
                misalign = |eff_addr[1:0];            // word not on 4 byte boundary
                base_be  = 4'b1111;
            end
        endcase
    end

    // own exception joins the incoming ones
    always_comb begin
        exp_next          = mem_exp_in;
        exp_next[exc_ale] = mem_exp_in[exc_ale] | misalign;
    end

    // ram only sees clean accepted requests
    assign ram_valid = accept & ~misalign & ~(|mem_exp_in);
    assign ram_op    = mem_op_in;
    assign ram_addr  = {eff_addr[`MEM_ADDR_W-1:2], 2'b00};
    assign ram_be    = base_be << eff_addr[1:0];

    // store data copied to every lane, be picks the right one
    always_comb begin
        case (mem_width_in)
            width_byte: ram_wdata = {4{mem_data_in[7:0]}};
            width_half: ram_wdata = {2{mem_data_in[15:0]}};
            default:    ram_wdata = mem_data_in;
        endcase
    end

    // valid bit of stage reg
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            s1_en <= 1'b0;
        end else if (accept) begin
            s1_en <= 1'b1;
        end else if (!stall) begin
            s1_en <= 1'b0;                            // drained, bubble
        end
    end

    // side-band payload, frozen while stalled since accept is low then
    always_ff @(posedge clk) begin
        if (accept) begin
            s1_rd      <= mem_rd_in;
            s1_width   <= mem_width_in;
            s1_sign    <= mem_sign_in;
            s1_addr_lo <= eff_addr[1:0];              // lane select for load
            s1_exp     <= exp_next;
            s1_badv    <= eff_addr;                   // used on ale
        end
    end

endmodule

// ==== mem_resp_stage.sv ====
`timescale 1ns/1ps
`include "mem_params.svh"

module mem_resp_stage
    import lsu_pkg::*, exc_pkg::*;
(
    // stage register from req stage
    input  logic                   s1_en,
    input  logic [`MEM_RD_W-1:0]   s1_rd,
    input  access_width_e          s1_width,
    input  logic                   s1_sign,
    input  logic [1:0]             s1_addr_lo,
    input  logic [`MEM_EXP_W-1:0]  s1_exp,
    input  logic [`MEM_ADDR_W-1:0] s1_badv,
    // from data ram
    input  logic                   data_valid,
    input  logic [`MEM_DATA_W-1:0] rdata,
    input  logic [`MEM_EXP_W-1:0]  ram_exception,
    input  logic [`MEM_ADDR_W-1:0] ram_badv,
    // global hold
    output logic                   stall,
    // writeback
    output logic                   mem_en_out,
    output logic [`MEM_RD_W-1:0]   mem_rd_out,
    output logic [`MEM_DATA_W-1:0] mem_data_out,
    output logic [`MEM_EXP_W-1:0]  mem_exp_out,
    output logic [`MEM_ADDR_W-1:0] badv_out
);

    logic                   s1_has_exp;
    logic                   done;
    logic [`MEM_EXP_W-1:0]  exp_all;
    logic                   has_exc;
    logic [`MEM_DATA_W-1:0] lane;
    logic [`MEM_DATA_W-1:0] load_ext;

    assign s1_has_exp = |s1_exp;       // faulted early, never went to ram

    // hold pipe while the ram still owes us a word
    assign stall = s1_en & ~(data_valid | s1_has_exp);
    assign done  = s1_en & (data_valid | s1_has_exp);

    // ram flags only count on its valid cycle
    assign exp_all = s1_exp | ({`MEM_EXP_W{data_valid}} & ram_exception);
    assign has_exc = |exp_all;

    // move addressed byte/half down to bit 0
    assign lane = rdata >> {s1_addr_lo, 3'b000};

    always_comb begin
        case (s1_width)
            width_byte: load_ext = {{24{s1_sign & lane[7]}}, lane[7:0]};
            width_half: load_ext = {{16{s1_sign & lane[15]}}, lane[15:0]};
            default:    load_ext = rdata;                     // full word
        endcase
    end

    assign mem_en_out   = done;
    assign mem_exp_out  = done ? exp_all : '0;
    assign mem_rd_out   = (done && !has_exc) ? s1_rd : '0;     // no writeback on fault
    assign mem_data_out = (done && !has_exc) ? load_ext : '0;

    // bad address source depends on who raised it
    always_comb begin
        if (!done) begin
            badv_out = '0;
        end else if (exp_all[exc_ale]) begin
            badv_out = s1_badv;                               // agu result
        end else if (exp_all[exc_adem]) begin
            // ram sees the word address, low bits come back from stage reg
            badv_out = {ram_badv[`MEM_ADDR_W-1:2], s1_addr_lo};
        end else begin
            badv_out = '0;
        end
    end

endmodule

// ==== mem_stage_tb.sv ====
`timescale 1ns/1ps
`include "mem_params.svh"

module mem_stage_tb
    import lsu_pkg::*, exc_pkg::*;
();

    localparam int max_entries = 64;
    localparam int wait_limit  = 20;                  // cycles before giving up on stall
    localparam logic [`MEM_EXP_W-1:0] ale_mask  = 1 << exc_ale;
    localparam logic [`MEM_EXP_W-1:0] adem_mask = 1 << exc_adem;

    logic                   clk;
    logic                   rst_n;
    logic                   mem_en_in;
    logic [`MEM_RD_W-1:0]   mem_rd_in;
    logic [`MEM_DATA_W-1:0] mem_data_in;
    logic [`MEM_ADDR_W-1:0] mem_base;
    logic [`MEM_ADDR_W-1:0] mem_offset;
    mem_op_e                mem_op_in;
    access_width_e          mem_width_in;
    logic                   mem_sign_in;
    logic [`MEM_EXP_W-1:0]  mem_exp_in;
    logic                   stall;
    logic                   mem_en_out;
    logic [`MEM_RD_W-1:0]   mem_rd_out;
    logic [`MEM_DATA_W-1:0] mem_data_out;
    logic [`MEM_EXP_W-1:0]  mem_exp_out;
    logic [`MEM_ADDR_W-1:0] badv_out;

    // stimulus table, one column per array
    string                  t_name    [0:max_entries-1];
    mem_op_e                t_op      [0:max_entries-1];
    access_width_e          t_width   [0:max_entries-1];
    logic                   t_sign    [0:max_entries-1];
    logic [`MEM_ADDR_W-1:0] t_base    [0:max_entries-1];
    logic [`MEM_ADDR_W-1:0] t_off     [0:max_entries-1];
    logic [`MEM_DATA_W-1:0] t_wdata   [0:max_entries-1];
    logic [`MEM_EXP_W-1:0]  t_exp_in  [0:max_entries-1];
    logic [`MEM_EXP_W-1:0]  t_exp_exc [0:max_entries-1];   // expected exception vector
    int                     n_entries;

    logic [7:0]             shadow [0:4*`MEM_RAM_WORDS-1]; // byte image of the ram
    int                     errors;
    int                     checks;
    logic [31:0]            rng;

    mem_stage_top u_mem_stage_top (
        .clk          (clk),
        .rst_n        (rst_n),
        .mem_en_in    (mem_en_in),
        .mem_rd_in    (mem_rd_in),
        .mem_data_in  (mem_data_in),
        .mem_base     (mem_base),
        .mem_offset   (mem_offset),
        .mem_op_in    (mem_op_in),
        .mem_width_in (mem_width_in),
        .mem_sign_in  (mem_sign_in),
        .mem_exp_in   (mem_exp_in),
        .stall        (stall),
        .mem_en_out   (mem_en_out),
        .mem_rd_out   (mem_rd_out),
        .mem_data_out (mem_data_out),
        .mem_exp_out  (mem_exp_out),
        .badv_out     (badv_out)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;                       // 40 ns period
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic add_entry(input string name, input mem_op_e op, input access_width_e w,
                             input logic sgn, input logic [31:0] base, off, data,
                             input logic [`MEM_EXP_W-1:0] exp_in, exp_exc);
        t_name[n_entries]    = name;
        t_op[n_entries]      = op;
        t_width[n_entries]   = w;
        t_sign[n_entries]    = sgn;
        t_base[n_entries]    = base;
        t_off[n_entries]     = off;
        t_wdata[n_entries]   = data;
        t_exp_in[n_entries]  = exp_in;
        t_exp_exc[n_entries] = exp_exc;
        n_entries++;
    endtask

    // little endian view of the shadow bytes, extended per width
    function automatic logic [31:0] model_load(input logic [31:0] addr, input access_width_e w,
                                               input logic sgn);
        logic [9:0] a;
        a = addr[9:0];
        case (w)
            width_byte: return {{24{sgn & shadow[a][7]}}, shadow[a]};
            width_half: return {{16{sgn & shadow[a+1][7]}}, shadow[a+1], shadow[a]};
            default:    return {shadow[a+3], shadow[a+2], shadow[a+1], shadow[a]};
        endcase
    endfunction

    task automatic store_model(input logic [31:0] addr, input access_width_e w,
                               input logic [31:0] data);
        int nbytes;
        nbytes = (w == width_byte) ? 1 : (w == width_half) ? 2 : 4;
        for (int b = 0; b < nbytes; b++) begin
            shadow[addr[9:0] + b] = data[8*b +: 8];   // low bytes of the operand
        end
    endtask

    task automatic check_val(input string name, input string what, input logic [31:0] exp,
                             input logic [31:0] act);
        checks++;
        assert (act === exp) else begin
            errors++;
            $display("Mismatch %s %s expected %h actual %h", name, what, exp, act);
        end
    endtask

    // writeback quiet outside a completion cycle
    task automatic check_idle(input string name);
        check_val(name, "idle en", 32'h0, {31'b0, mem_en_out});
        check_val(name, "idle rd", 32'h0, mem_rd_out);
        check_val(name, "idle data", 32'h0, mem_data_out);
        check_val(name, "idle exc", 32'h0, mem_exp_out);
    endtask

    task automatic build_table();
        logic [31:0]   off;
        logic [31:0]   data;
        access_width_e w;
        // known words first so loads never see an unwritten location
        add_entry("init_w40", op_store, width_word, 0, 32'h30, 32'h10, 32'h11223344, 0, 0);
        add_entry("init_w44", op_store, width_word, 0, 32'h40, 32'h4, 32'h8899aabb, 0, 0);
        add_entry("init_w48", op_store, width_word, 0, 32'h48, 32'h0, 32'hf0e1d2c3, 0, 0);
        add_entry("sb_lane1", op_store, width_byte, 0, 32'h40, 32'h1, 32'h123456a5, 0, 0);
        add_entry("sh_upper44", op_store, width_half, 0, 32'h40, 32'h6, 32'hcafebeef, 0, 0);
        add_entry("sb_lane3", op_store, width_byte, 0, 32'h43, 32'h0, 32'h000000f7, 0, 0);
        add_entry("lw_merged40", op_load, width_word, 0, 32'h40, 0, 0, 0, 0);
        add_entry("lw_merged44", op_load, width_word, 0, 32'h44, 0, 0, 0, 0);
        add_entry("sh_lower48", op_store, width_half, 0, 32'h48, 0, 32'h55aa1234, 0, 0);
        add_entry("sb_lane2_48", op_store, width_byte, 0, 32'h48, 32'h2, 32'h00000099, 0, 0);
        add_entry("lw_merged48", op_load, width_word, 0, 32'h48, 0, 0, 0, 0);
        for (int k = 0; k < 8; k++) begin                  // every byte lane, zero then sign
            add_entry($sformatf("lb_off%0d_s%0d", k % 4, k / 4), op_load, width_byte,
                      k >= 4, 32'h44, k % 4, 0, 0, 0);
        end
        for (int k = 0; k < 8; k++) begin                  // halves across 0x40..0x47
            add_entry($sformatf("lh_off%0d_s%0d", 2 * (k % 4), k / 4), op_load, width_half,
                      k >= 4, 32'h40, 2 * (k % 4), 0, 0, 0);
        end
        // misaligned, memory must stay as it was
        add_entry("sh_odd", op_store, width_half, 0, 32'h40, 32'h1, 32'h0000ffff, 0, ale_mask);
        add_entry("lw_after_sh_odd", op_load, width_word, 0, 32'h40, 0, 0, 0, 0);
        add_entry("lw_off2", op_load, width_word, 0, 32'h44, 32'h2, 0, 0, ale_mask);
        add_entry("sw_off3", op_store, width_word, 0, 32'h48, 32'h3, 32'h0, 0, ale_mask);
        add_entry("lh_odd_ipe", op_load, width_half, 1, 32'h43, 0, 0, 1 << exc_ipe,
                  (1 << exc_ipe) | ale_mask);
        add_entry("lw_after_sw_off3", op_load, width_word, 0, 32'h48, 0, 0, 0, 0);
        // out of range, first illegal word and beyond
        add_entry("lw_range_edge", op_load, width_word, 0, 32'h3f0, 32'h10, 0, 0, adem_mask);
        add_entry("sw_far", op_store, width_word, 0, 32'h1000, 0, 32'h12345678, 0, adem_mask);
        add_entry("lb_range3", op_load, width_byte, 1, 32'h400, 32'h3, 0, 0, adem_mask);
        // upstream faults pass through and block the access
        add_entry("sw_with_ine", op_store, width_word, 0, 32'h40, 0, 32'h0, 1 << exc_ine,
                  1 << exc_ine);
        add_entry("lw_after_ine", op_load, width_word, 0, 32'h40, 0, 0, 0, 0);
        add_entry("lb_with_int", op_load, width_byte, 0, 32'h44, 32'h1, 0, 1 << exc_int,
                  1 << exc_int);
        // random partial stores into 0x100..0x10f
        for (int k = 0; k < 4; k++) begin
            rng = xorshift32(rng);
            add_entry("rnd_init", op_store, width_word, 0, 32'h100, 4 * k, rng, 0, 0);
        end
        for (int k = 0; k < 12; k++) begin
            rng  = xorshift32(rng);
            w    = rng[4] ? width_half : width_byte;
            off  = rng[4] ? {28'd0, rng[3:1], 1'b0} : {28'd0, rng[3:0]};  // aligned lane
            rng  = xorshift32(rng);
            data = rng;
            add_entry($sformatf("rnd_st%0d", k), op_store, w, 0, 32'h100, off, data, 0, 0);
        end
        for (int k = 0; k < 4; k++) begin
            add_entry($sformatf("rnd_lw%0d", k), op_load, width_word, 0, 32'h100, 4 * k,
                      0, 0, 0);
        end
    endtask

    task automatic run_entry(input int i);
        logic [31:0]          addr;
        logic [31:0]          exp_data;
        logic [31:0]          exp_badv;
        logic [`MEM_RD_W-1:0] rd_val;
        logic [`MEM_RD_W-1:0] exp_rd;
        int                   exp_stall;
        int                   stall_cyc;
        addr      = t_base[i] + t_off[i];
        rd_val    = (i % 31) + 1;                          // never r0
        exp_rd    = (t_exp_exc[i] == 0) ? rd_val : '0;
        exp_data  = (t_exp_exc[i] == 0 && t_op[i] == op_load) ?
                    model_load(addr, t_width[i], t_sign[i]) : 32'h0;
        exp_badv  = ((t_exp_exc[i] & (ale_mask | adem_mask)) != 0) ? addr : 32'h0;
        exp_stall = ((t_exp_exc[i] & ~adem_mask) == 0) ? `MEM_RAM_LAT - 1 : 0;
        @(posedge clk);
        mem_en_in    <= 1'b1;
        mem_rd_in    <= rd_val;
        mem_data_in  <= t_wdata[i];
        mem_base     <= t_base[i];
        mem_offset   <= t_off[i];
        mem_op_in    <= t_op[i];
        mem_width_in <= t_width[i];
        mem_sign_in  <= t_sign[i];
        mem_exp_in   <= t_exp_in[i];
        @(negedge clk);
        check_idle(t_name[i]);                             // previous access drained
        @(posedge clk);                                    // accepted here, stall is low
        mem_en_in <= 1'b0;
        stall_cyc = 0;
        @(negedge clk);
        while (stall) begin
            check_idle(t_name[i]);                         // nothing completes yet
            stall_cyc++;
            if (stall_cyc > wait_limit) begin
                $display("timeout, stall stayed high during %s", t_name[i]);
                $display("Test failures found");
                $finish;
            end else begin
                @(negedge clk);
            end
        end
        check_val(t_name[i], "en", 32'h1, {31'b0, mem_en_out});
        check_val(t_name[i], "rd", exp_rd, mem_rd_out);
        check_val(t_name[i], "data", exp_data, mem_data_out);
        check_val(t_name[i], "exc", t_exp_exc[i], mem_exp_out);
        check_val(t_name[i], "badv", exp_badv, badv_out);
        check_val(t_name[i], "stall cycles", exp_stall, stall_cyc);
        if (t_op[i] == op_store && t_exp_exc[i] == 0) begin
            store_model(addr, t_width[i], t_wdata[i]);
        end
    endtask

    initial begin
        rst_n        = 1'b0;
        mem_en_in    = 1'b0;
        mem_rd_in    = '0;
        mem_data_in  = '0;
        mem_base     = '0;
        mem_offset   = '0;
        mem_op_in    = op_load;
        mem_width_in = width_byte;
        mem_sign_in  = 1'b0;
        mem_exp_in   = '0;
        errors       = 0;
        checks       = 0;
        n_entries    = 0;
        rng          = 32'h934;
        build_table();
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_val("reset", "stall", 32'h0, {31'b0, stall});
        check_idle("reset");
        for (int i = 0; i < n_entries; i++) begin
            run_entry(i);
        end
        $display("summary: %0d entries, %0d checks, %0d errors", n_entries, checks, errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

// ==== mem_stage_top.sv ====
`timescale 1ns/1ps
`include "mem_params.svh"

module mem_stage_top
    import lsu_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst_n,
    // upstream request
    input  logic                   mem_en_in,
    input  logic [`MEM_RD_W-1:0]   mem_rd_in,
    input  logic [`MEM_DATA_W-1:0] mem_data_in,
    input  logic [`MEM_ADDR_W-1:0] mem_base,
    input  logic [`MEM_ADDR_W-1:0] mem_offset,
    input  mem_op_e                mem_op_in,
    input  access_width_e          mem_width_in,
    input  logic                   mem_sign_in,
    input  logic [`MEM_EXP_W-1:0]  mem_exp_in,
    output logic                   stall,
    // writeback
    output logic                   mem_en_out,
    output logic [`MEM_RD_W-1:0]   mem_rd_out,
    output logic [`MEM_DATA_W-1:0] mem_data_out,
    output logic [`MEM_EXP_W-1:0]  mem_exp_out,
    output logic [`MEM_ADDR_W-1:0] badv_out
);

    // req stage -> ram
    logic                   ram_valid;
    mem_op_e                ram_op;
    logic [`MEM_ADDR_W-1:0] ram_addr;
    logic [`MEM_BE_W-1:0]   ram_be;
    logic [`MEM_DATA_W-1:0] ram_wdata;
    // ram -> resp stage
    logic                   data_valid;
    logic [`MEM_DATA_W-1:0] rdata;
    logic [`MEM_EXP_W-1:0]  ram_exception;
    logic [`MEM_ADDR_W-1:0] ram_badv;
    // stage register
    logic                   s1_en;
    logic [`MEM_RD_W-1:0]   s1_rd;
    access_width_e          s1_width;
    logic                   s1_sign;
    logic [1:0]             s1_addr_lo;
    logic [`MEM_EXP_W-1:0]  s1_exp;
    logic [`MEM_ADDR_W-1:0] s1_badv;

    mem_req_stage u_mem_req_stage (
        .clk          (clk),
        .rst_n        (rst_n),
        .mem_en_in    (mem_en_in),
        .mem_rd_in    (mem_rd_in),
        .mem_data_in  (mem_data_in),
        .mem_base     (mem_base),
        .mem_offset   (mem_offset),
        .mem_op_in    (mem_op_in),
        .mem_width_in (mem_width_in),
        .mem_sign_in  (mem_sign_in),
        .mem_exp_in   (mem_exp_in),
        .stall        (stall),
        .ram_valid    (ram_valid),
        .ram_op       (ram_op),
        .ram_addr     (ram_addr),
        .ram_be       (ram_be),
        .ram_wdata    (ram_wdata),
        .s1_en        (s1_en),
        .s1_rd        (s1_rd),
        .s1_width     (s1_width),
        .s1_sign      (s1_sign),
        .s1_addr_lo   (s1_addr_lo),
        .s1_exp       (s1_exp),
        .s1_badv      (s1_badv)
    );

    data_ram u_data_ram (
        .clk           (clk),
        .rst_n         (rst_n),
        .ram_valid     (ram_valid),
        .ram_op        (ram_op),
        .ram_addr      (ram_addr),
        .ram_be        (ram_be),
        .ram_wdata     (ram_wdata),
        .data_valid    (data_valid),
        .rdata         (rdata),
        .ram_exception (ram_exception),
        .ram_badv      (ram_badv)
    );

    mem_resp_stage u_mem_resp_stage (
        .s1_en         (s1_en),
        .s1_rd         (s1_rd),
        .s1_width      (s1_width),
        .s1_sign       (s1_sign),
        .s1_addr_lo    (s1_addr_lo),
        .s1_exp        (s1_exp),
        .s1_badv       (s1_badv),
        .data_valid    (data_valid),
        .rdata         (rdata),
        .ram_exception (ram_exception),
        .ram_badv      (ram_badv),
        .stall         (stall),
        .mem_en_out    (mem_en_out),
        .mem_rd_out    (mem_rd_out),
        .mem_data_out  (mem_data_out),
        .mem_exp_out   (mem_exp_out),
        .badv_out      (badv_out)
    );

endmodule
